// File: all.f
+incdir+src
src/rcd_pkg.sv
src/rcd_cmd_decode.sv
src/rcd_side_drive.sv
src/rcd_alert_log.sv
src/rcd_top.sv
sim/tb_rcd.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the RCD testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rcd -f all.f -o sim_rcd
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_rcd 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
else
  exit 1
fi

// File: sim/tb_rcd.sv
// testbench for rcd_top: directed and random commands against a reference model, checked by assertions
`timescale 1ns/10ps
`include "rcd_cfg.svh"

module tb_rcd;

  localparam int n_random  = 300;                   // random good-parity commands
  localparam int cyc_limit = 4 * (n_random + 200);  // roughly four times the whole run

  // one slot of the reference pipeline
  typedef struct packed {
    logic              known;  // low while reset values are still in flight
    logic              perr;
    rcd_pkg::rcd_cmd_t cmd;
  } stage_t;

  logic              ck_t = 1'b0;
  logic              rst_n;
  rcd_pkg::ctrl_ca_t ca;
  rcd_pkg::rcd_cmd_t qa;
  rcd_pkg::rcd_cmd_t qb;
  logic              alert_n;
  logic              err_req;
  logic              err_ack;
  rcd_pkg::err_log_t err_log;

  stage_t            st1;              // model after the decode edge
  stage_t            st2;              // model after the output edge
  int                alert_left = 0;   // model alert cycles still to run
  logic              exp_ack = 1'b0;
  int                cyc = 0;
  integer            seed = 32'h3df1_ff93;
  rcd_pkg::rcd_cmd_t first_err;        // padded copy of the first bad command
  rcd_pkg::err_log_t got;

  rcd_top uut
  (
    .ck_t    (ck_t),
    .rst_n   (rst_n),
    .ca      (ca),
    .qa      (qa),
    .qb      (qb),
    .alert_n (alert_n),
    .err_req (err_req),
    .err_ack (err_ack),
    .err_log (err_log)
  );

  always #5 ck_t = ~ck_t;  // 10 ns period

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  // ========================================
  // reference model
  // ========================================
  function automatic rcd_pkg::rcd_op_e decode_op(input rcd_pkg::ctrl_ca_t c);
    if (&c.cs_n)
      return rcd_pkg::DES;   // padded selects are ones, so only these count
    if (!c.act_n)
      return rcd_pkg::ACT;
    case (c.addr[16:14])     // ras_n, cas_n, we_n
      3'b000:  return rcd_pkg::MRS;
      3'b001:  return rcd_pkg::REF;
      3'b010:  return rcd_pkg::PRE;
      3'b100:  return rcd_pkg::WR;
      3'b101:  return rcd_pkg::RD;
      3'b110:  return rcd_pkg::ZQC;
      default: return rcd_pkg::NOP;
    endcase
  endfunction

  function automatic rcd_pkg::rcd_cmd_t pad_cmd(input rcd_pkg::ctrl_ca_t c);
    rcd_pkg::rcd_cmd_t p;
    p = '0;                                  // zero padding by default
    p.act_n = c.act_n;
    p.addr[`RCD_MC_ABITS-1:0] = c.addr;
    p.ba = c.ba;
    p.bg[`RCD_MC_BG-1:0] = c.bg;
    p.cs_n = '1;                             // unused ranks deselected
    p.cs_n[`RCD_MC_CS_NUM-1:0] = c.cs_n;
    p.cke[0] = c.cke;
    p.odt[0] = c.odt;
    p.par = c.par;
    p.op = decode_op(c);
    return p;
  endfunction

  function automatic logic parity_bad(input rcd_pkg::ctrl_ca_t c);
    return (decode_op(c) != rcd_pkg::DES) && (^{c.act_n, c.addr, c.ba, c.bg, c.par});
  endfunction

  function automatic rcd_pkg::rcd_cmd_t mirror_cmd(input rcd_pkg::rcd_cmd_t c);
    rcd_pkg::rcd_cmd_t m;
    m = c;
    {m.addr[3], m.addr[4]}   = {c.addr[4], c.addr[3]};
    {m.addr[5], m.addr[6]}   = {c.addr[6], c.addr[5]};
    {m.addr[7], m.addr[8]}   = {c.addr[8], c.addr[7]};
    {m.addr[11], m.addr[13]} = {c.addr[13], c.addr[11]};
    {m.ba[0], m.ba[1]}       = {c.ba[1], c.ba[0]};
    {m.bg[0], m.bg[1]}       = {c.bg[1], c.bg[0]};
    return m;
  endfunction

  function automatic rcd_pkg::rcd_cmd_t expect_side(input stage_t s, input bit mir);
    rcd_pkg::rcd_cmd_t e;
    e = mir ? mirror_cmd(s.cmd) : s.cmd;
    if (s.perr)
    begin
      e.cs_n = '1;          // blocked to deselect
      e.op   = rcd_pkg::DES;
    end
    return e;
  endfunction

  // only the idle fields are defined while reset values drain
  function automatic bit side_match(input rcd_pkg::rcd_cmd_t q, input stage_t s, input bit mir);
    if (s.known !== 1'b1)
      return (q.cs_n == '1) && (q.cke == '0) && (q.odt == '0) && (q.op == rcd_pkg::DES);
    return q === expect_side(s, mir);
  endfunction

  always @(posedge ck_t)
  begin
    if (!rst_n)
    begin
      st1        <= '0;
      st2        <= '0;
      alert_left <= 0;
      exp_ack    <= 1'b0;
    end
    else
    begin
      st1.known <= 1'b1;
      st1.perr  <= parity_bad(ca);
      st1.cmd   <= pad_cmd(ca);
      st2       <= st1;
      if (st1.perr)
        alert_left <= `RCD_ALERT_CYCLES;   // restart on every error
      else if (alert_left > 0)
        alert_left <= alert_left - 1;
      exp_ack <= err_req;
    end
  end

  always @(posedge ck_t)
  begin
    cyc <= cyc + 1;
    if (cyc >= cyc_limit)
      abort_run($sformatf("timeout: no result after %0d clock cycles", cyc));
  end

  // ========================================
  // checks, sampled at the falling edge
  // ========================================
  qa_check: assert property (@(negedge ck_t) side_match(qa, st2, 1'b0))
    else abort_run($sformatf("ERR %0t qa exp=%h got=%h", $time, expect_side(st2, 1'b0), qa));
  qb_check: assert property (@(negedge ck_t) side_match(qb, st2, `RCD_CA_MIRROR))
    else abort_run($sformatf("ERR %0t qb exp=%h got=%h", $time,
                             expect_side(st2, `RCD_CA_MIRROR), qb));
  alert_check: assert property (@(negedge ck_t) alert_n == (alert_left == 0))
    else abort_run($sformatf("ERR %0t alert_n exp=%b got=%b", $time, alert_left == 0, alert_n));
  ack_check: assert property (@(negedge ck_t) err_ack == exp_ack)
    else abort_run($sformatf("ERR %0t err_ack exp=%b got=%b", $time, exp_ack, err_ack));

  // ========================================
  // stimulus helpers
  // ========================================
  function automatic rcd_pkg::ctrl_ca_t with_parity(input rcd_pkg::ctrl_ca_t c, input bit good);
    rcd_pkg::ctrl_ca_t r;
    r = c;
    r.par = (^{c.act_n, c.addr, c.ba, c.bg}) ^ !good;  // flipped when corrupt
    return r;
  endfunction

  function automatic rcd_pkg::ctrl_ca_t rand_ca();
    logic [31:0] r;
    r = $random(seed);
    return with_parity(r[$bits(rcd_pkg::ctrl_ca_t)-1:0], 1'b1);
  endfunction

  function automatic rcd_pkg::ctrl_ca_t idle_ca();
    rcd_pkg::ctrl_ca_t c;
    c = '0;
    c.cs_n = '1;
    return c;
  endfunction

  task automatic send(input rcd_pkg::ctrl_ca_t c);
    @(posedge ck_t);
    ca <= c;
  endtask

  // full four-phase read, returns the log seen while ack is high
  task automatic read_log(output rcd_pkg::err_log_t lg);
    @(posedge ck_t);
    err_req <= 1'b1;
    do @(negedge ck_t); while (err_ack !== 1'b1);
    lg = err_log;
    @(posedge ck_t);
    err_req <= 1'b0;
    do @(negedge ck_t); while (err_ack !== 1'b0);
  endtask

  initial
  begin
    rcd_pkg::ctrl_ca_t c;
    int low;
    rst_n   = 1'b0;
    err_req = 1'b0;
    ca      = idle_ca();
    repeat (5) @(posedge ck_t);
    rst_n <= 1'b1;

    // every ras/cas/we pattern, then activate, then deselect
    for (int p = 0; p < 10; p++)
    begin
      c = rand_ca();
      c.cs_n = (p == 9) ? 2'b11 : 2'b10;
      c.act_n = (p != 8);
      c.addr[16:14] = 3'(p);
      send(with_parity(c, 1'b1));
    end
    repeat (n_random) send(rand_ca());
    send(idle_ca());

    // ========================================
    // parity errors and alert
    // ========================================
    c = rand_ca();
    c.cs_n = 2'b01;
    c.act_n = 1'b0;
    first_err = pad_cmd(c);
    send(with_parity(c, 1'b0));
    send(idle_ca());
    do @(negedge ck_t); while (alert_n);
    low = 0;
    while (!alert_n)
    begin
      low++;
      @(negedge ck_t);
    end
    assert (low == `RCD_ALERT_CYCLES)
      else abort_run($sformatf("ERR %0t alert_n low cycles exp=%0d got=%0d", $time,
                               `RCD_ALERT_CYCLES, low));

    c = rand_ca();
    c.cs_n = 2'b11;             // bad parity on a deselect, no alert
    send(with_parity(c, 1'b0));
    send(idle_ca());
    repeat (`RCD_ALERT_CYCLES + 4) @(posedge ck_t);

    repeat (2)
    begin
      c = rand_ca();
      c.cs_n = 2'b10;
      send(with_parity(c, 1'b0));
    end
    send(idle_ca());
    repeat (3) @(posedge ck_t);

    // log readout, first error kept with count 3, then empty
    read_log(got);
    assert (got.op == first_err.op && got.addr == first_err.addr && got.cs_n == first_err.cs_n)
      else abort_run($sformatf("ERR %0t err_log exp=%0d/%h/%b got=%0d/%h/%b", $time,
                               first_err.op, first_err.addr, first_err.cs_n,
                               got.op, got.addr, got.cs_n));
    assert (got.cnt == 3)
      else abort_run($sformatf("ERR %0t err_log.cnt exp=3 got=%0d", $time, got.cnt));
    read_log(got);
    assert (got.cnt == 0)
      else abort_run($sformatf("ERR %0t err_log.cnt exp=0 got=%0d", $time, got.cnt));
    repeat (4) @(posedge ck_t);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: src/rcd_alert_log.sv
// rcd error handling: alert_n pulse, first-error log and its four-phase req/ack readout
`timescale 1ns/10ps
`include "rcd_cfg.svh"

module rcd_alert_log
(
  input  logic              ck_t,     // dimm clock
  input  logic              rst_n,    // sync reset, active low
  input  rcd_pkg::rcd_cmd_t cmd,      // decoded command, before blocking
  input  logic              perr,     // parity error on cmd
  output logic              alert_n,  // low while the error pulse runs
  input  logic              err_req,  // controller read request
  output logic              err_ack,  // log valid for the controller
  output rcd_pkg::err_log_t err_log   // first unread error and count
);

  localparam int alert_w = $clog2(`RCD_ALERT_CYCLES + 1);
  localparam logic [alert_w-1:0] alert_len = alert_w'(`RCD_ALERT_CYCLES);

  logic [alert_w-1:0] alert_cnt;  // remaining low cycles
  logic               log_clr;    // last phase of the readout
  logic               log_empty;  // nothing captured yet

  // ========================================
  // alert pulse
  // ========================================
  always_ff @(posedge ck_t)
  begin
    if (!rst_n)
      alert_cnt <= '0;
    else if (perr)
      alert_cnt <= alert_len;           // new error restarts the pulse
    else if (alert_cnt != '0)
      alert_cnt <= alert_cnt - 1'b1;
  end

  assign alert_n = (alert_cnt == '0);   // open-drain style, low active

  // ========================================
  // readout handshake and log
  // ========================================
  assign log_clr   = err_ack && !err_req;          // req dropped, ack about to fall
  assign log_empty = (err_log.cnt == '0);

  always_ff @(posedge ck_t)
  begin
    if (!rst_n)
      err_ack <= 1'b0;
    else
      err_ack <= err_req;               // follows req one cycle late
  end

  always_ff @(posedge ck_t)
  begin
    if (!rst_n)
      err_log <= rcd_pkg::log_empty;
    else if (perr && (log_empty || log_clr))
    begin
      err_log.op   <= cmd.op;           // fresh log on the first error
      err_log.addr <= cmd.addr;
      err_log.cs_n <= cmd.cs_n;
      err_log.cnt  <= `RCD_ERR_CNT_W'(1);
    end
    else if (log_clr)
      err_log <= rcd_pkg::log_empty;    // read done
    else if (perr && (err_log.cnt != '1))
      err_log.cnt <= err_log.cnt + 1'b1; // saturating count
  end

endmodule

// File: src/rcd_cfg.svh
// rcd widths, alert pulse length and mirroring, included by every file that needs them
`ifndef RCD_CFG_SVH
`define RCD_CFG_SVH

// ========================================
// controller side widths
// ========================================
`define RCD_MC_ABITS      17  // controller address bits
`define RCD_MC_CS_NUM     2   // controller chip selects
`define RCD_MC_BG         1   // controller bank group bits

// ========================================
// rcd side widths
// ========================================
`define RCD_ABITS         18  // full rcd address
`define RCD_CS_NUM        4   // full rcd chip selects
`define RCD_BG            2   // full rcd bank group
`define RCD_CKE_NUM       2   // rcd cke outputs, controller drives bit 0
`define RCD_ODT_NUM       2   // rcd odt outputs, controller drives bit 0

// ========================================
// error handling and side b
// ========================================
`define RCD_ALERT_CYCLES  6   // alert_n low time in ck_t cycles
`define RCD_ERR_CNT_W     8   // saturating error count width
`define RCD_CA_MIRROR     1   // side b carries mirrored address

`endif

// File: src/rcd_cmd_decode.sv
// rcd input stage: pads the controller bus, decodes the command, checks parity, one cycle
`timescale 1ns/10ps
`include "rcd_cfg.svh"

module rcd_cmd_decode
(
  input  logic              ck_t,   // dimm clock, rising edge
  input  logic              rst_n,  // sync reset, active low
  input  rcd_pkg::ctrl_ca_t ca,     // controller command/address
  output rcd_pkg::rcd_cmd_t cmd,    // padded and decoded, registered
  output logic              perr    // parity error for cmd, registered
);

  localparam int addr_pad = `RCD_ABITS - `RCD_MC_ABITS;     // upper address bits
  localparam int cs_pad   = `RCD_CS_NUM - `RCD_MC_CS_NUM;   // unused chip selects
  localparam int bg_pad   = `RCD_BG - `RCD_MC_BG;
  localparam int cke_pad  = `RCD_CKE_NUM - 1;
  localparam int odt_pad  = `RCD_ODT_NUM - 1;

  rcd_pkg::rcd_cmd_t pad;     // command at rcd widths
  logic              par_bad; // parity mismatch on an active command

  // ========================================
  // padding and opcode decode
  // ========================================
  always_comb
  begin
    pad.act_n = ca.act_n;
    pad.addr  = {{addr_pad{1'b0}}, ca.addr};  // zeros above the controller width
    pad.ba    = ca.ba;
    pad.bg    = {{bg_pad{1'b0}}, ca.bg};
    pad.cs_n  = {{cs_pad{1'b1}}, ca.cs_n};    // unused ranks stay deselected
    pad.cke   = {{cke_pad{1'b0}}, ca.cke};
    pad.odt   = {{odt_pad{1'b0}}, ca.odt};
    pad.par   = ca.par;

    if (&pad.cs_n)            // no rank selected
      pad.op = rcd_pkg::DES;
    else if (!ca.act_n)       // act_n overrides ras/cas/we
      pad.op = rcd_pkg::ACT;
    else
    begin
      case (pad.addr[16:14])  // ras_n, cas_n, we_n
        3'b000:  pad.op = rcd_pkg::MRS;
        3'b001:  pad.op = rcd_pkg::REF;
        3'b010:  pad.op = rcd_pkg::PRE;
        3'b100:  pad.op = rcd_pkg::WR;
        3'b101:  pad.op = rcd_pkg::RD;
        3'b110:  pad.op = rcd_pkg::ZQC;
        3'b111:  pad.op = rcd_pkg::NOP;
        default: pad.op = rcd_pkg::NOP;  // 011 is reserved
      endcase
    end
  end

  // even parity over the controller fields, ignored on deselect
  assign par_bad = (pad.op != rcd_pkg::DES) &&
                   (^{ca.act_n, ca.addr, ca.ba, ca.bg, ca.par});

  // ========================================
  // input register
  // ========================================
  always_ff @(posedge ck_t)
  begin
    if (!rst_n)
    begin
      cmd  <= rcd_pkg::cmd_idle;  // bus idles deselected
      perr <= 1'b0;
    end
    else
    begin
      cmd  <= pad;
      perr <= par_bad;
    end
  end

endmodule

// File: src/rcd_pkg.sv
// shared rcd types: command opcodes and the packed buses passed between the stages
`include "rcd_cfg.svh"

package rcd_pkg;

  // decoded ddr4 command
  typedef enum logic [3:0] {
    DES = 4'd0,  // deselect, no chip select active
    ACT = 4'd1,  // activate
    MRS = 4'd2,  // mode register set
    REF = 4'd3,  // refresh
    PRE = 4'd4,  // precharge
    WR  = 4'd5,  // write
    RD  = 4'd6,  // read
    ZQC = 4'd7,  // zq calibration
    NOP = 4'd8   // no operation
  } rcd_op_e;

  // command/address bus as the controller drives it
  typedef struct packed {
    logic                      act_n;
    logic [`RCD_MC_ABITS-1:0]  addr;
    logic [1:0]                ba;    // bank address, same width both sides
    logic [`RCD_MC_BG-1:0]     bg;
    logic [`RCD_MC_CS_NUM-1:0] cs_n;
    logic                      cke;   // one cke from the controller
    logic                      odt;   // one odt from the controller
    logic                      par;   // even parity over act_n, addr, ba, bg
  } ctrl_ca_t;

  // command at full rcd widths, as seen on qa/qb
  typedef struct packed {
    logic                     act_n;
    logic [`RCD_ABITS-1:0]    addr;
    logic [1:0]               ba;
    logic [`RCD_BG-1:0]       bg;
    logic [`RCD_CS_NUM-1:0]   cs_n;
    logic [`RCD_CKE_NUM-1:0]  cke;
    logic [`RCD_ODT_NUM-1:0]  odt;
    logic                     par;
    rcd_op_e                  op;
  } rcd_cmd_t;

  // first unread parity error, cnt of zero means empty
  typedef struct packed {
    rcd_op_e                  op;
    logic [`RCD_ABITS-1:0]    addr;
    logic [`RCD_CS_NUM-1:0]   cs_n;
    logic [`RCD_ERR_CNT_W-1:0] cnt;
  } err_log_t;

  // idle bus: all ranks deselected, cke/odt low
  localparam rcd_cmd_t cmd_idle = '{act_n: 1'b1, addr: '0, ba: '0, bg: '0, cs_n: '1,
                                    cke: '0, odt: '0, par: 1'b0, op: DES};

  // nothing logged
  localparam err_log_t log_empty = '{op: DES, addr: '0, cs_n: '0, cnt: '0};

endpackage

// File: src/rcd_side_drive.sv
// one rcd output side: optional ddr4 address mirroring, deselect on parity error, one cycle
`timescale 1ns/10ps

module rcd_side_drive
#(
  parameter bit MIRROR = 1'b0   // 1 for the mirrored side b
)
(
  input  logic              ck_t,   // dimm clock
  input  logic              rst_n,  // sync reset, active low
  input  rcd_pkg::rcd_cmd_t cmd,    // decoded command from the input stage
  input  logic              perr,   // parity error on cmd
  output rcd_pkg::rcd_cmd_t q       // registered side output
);

  rcd_pkg::rcd_cmd_t mirr;  // after mirroring
  rcd_pkg::rcd_cmd_t nxt;   // after blocking

  // ========================================
  // address mirroring
  // ========================================
  always_comb
  begin
    mirr = cmd;
    if (MIRROR)
    begin
      mirr.addr[3]  = cmd.addr[4];    // a3/a4
      mirr.addr[4]  = cmd.addr[3];
      mirr.addr[5]  = cmd.addr[6];    // a5/a6
      mirr.addr[6]  = cmd.addr[5];
      mirr.addr[7]  = cmd.addr[8];    // a7/a8
      mirr.addr[8]  = cmd.addr[7];
      mirr.addr[11] = cmd.addr[13];   // a11/a13
      mirr.addr[13] = cmd.addr[11];
      mirr.ba[0]    = cmd.ba[1];      // ba0/ba1
      mirr.ba[1]    = cmd.ba[0];
      mirr.bg[0]    = cmd.bg[1];      // bg0/bg1
      mirr.bg[1]    = cmd.bg[0];
    end
  end

  // a command with bad parity never reaches the drams
  always_comb
  begin
    nxt = mirr;
    if (perr)
    begin
      nxt.cs_n = '1;            // deselect every rank
      nxt.op   = rcd_pkg::DES;
    end
  end

  // ========================================
  // output register
  // ========================================
  always_ff @(posedge ck_t)
  begin
    if (!rst_n)
      q <= rcd_pkg::cmd_idle;   // all ranks deselected, cke low
    else
      q <= nxt;
  end

endmodule

// File: src/rcd_top.sv
// rcd top level: input decode, side a and side b drivers, alert and error log
`timescale 1ns/10ps
`include "rcd_cfg.svh"

module rcd_top
(
  input  logic              ck_t,     // dimm clock from the controller
  input  logic              rst_n,    // sync reset, active low
  input  rcd_pkg::ctrl_ca_t ca,       // controller command/address
  output rcd_pkg::rcd_cmd_t qa,       // side a, unmirrored
  output rcd_pkg::rcd_cmd_t qb,       // side b, mirrored when enabled
  output logic              alert_n,  // parity alert to the controller
  input  logic              err_req,  // error log read request
  output logic              err_ack,  // error log read acknowledge
  output rcd_pkg::err_log_t err_log   // logged error
);

  rcd_pkg::rcd_cmd_t cmd;   // decoded command, stage 1
  logic              perr;  // parity error, stage 1

  // ========================================
  // stage 1 decode
  // ========================================
  rcd_cmd_decode u_decode
  (
    .ck_t  (ck_t),
    .rst_n (rst_n),
    .ca    (ca),
    .cmd   (cmd),
    .perr  (perr)
  );

  // ========================================
  // stage 2 outputs
  // ========================================
  rcd_side_drive #(.MIRROR(1'b0)) u_side_a
  (
    .ck_t  (ck_t),
    .rst_n (rst_n),
    .cmd   (cmd),
    .perr  (perr),
    .q     (qa)
  );

  rcd_side_drive #(.MIRROR(`RCD_CA_MIRROR)) u_side_b
  (
    .ck_t  (ck_t),
    .rst_n (rst_n),
    .cmd   (cmd),
    .perr  (perr),
    .q     (qb)
  );

  rcd_alert_log u_alert
  (
    .ck_t    (ck_t),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .perr    (perr),
    .alert_n (alert_n),
    .err_req (err_req),
    .err_ack (err_ack),
    .err_log (err_log)
  );

endmodule
